/* include/clint_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT build constants: hart count, bus widths, address map, tick divider
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CLINT_PARAMS_SVH
`define CLINT_PARAMS_SVH

// Harts served, 1 to 16
`define CLINT_HART_COUNT      4
`define CLINT_HART_ID_WIDTH   2

// Register bus
`define CLINT_ADDR_WIDTH      16
`define CLINT_DATA_WIDTH      32

// Address map, byte addresses
`define CLINT_MSIP_BASE       16'h0000
`define CLINT_MTIMECMP_BASE   16'h4000
`define CLINT_MTIME_ADDR      16'hBFF8

// clk cycles per mtime increment
`define CLINT_TICK_DIV        4

`endif

/* verilog/clint_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT types: bus vectors, time value, hart vectors, arbiter owner enum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "clint_params.svh"

package clint_pkg;

    // Register bus fields
    typedef logic [`CLINT_ADDR_WIDTH-1:0]   bus_addr_t;
    typedef logic [`CLINT_DATA_WIDTH-1:0]   bus_data_t;
    typedef logic [`CLINT_DATA_WIDTH/8-1:0] bus_strb_t;

    // mtime and mtimecmp are always 64 bits wide
    typedef logic [63:0] mtime_t;

    // Hart index and one-bit-per-hart vector
    typedef logic [`CLINT_HART_ID_WIDTH-1:0] hart_id_t;
    typedef logic [`CLINT_HART_COUNT-1:0]    hart_vec_t;

    // Master that owns a request in flight
    typedef enum logic {
        OWNER_M0,
        OWNER_M1
    } arb_owner_e;

endpackage

`default_nettype wire

/* verilog/clint_bus_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-master round-robin arbiter with a registered request stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clint_bus_arbiter (
    input  wire                       clk,
    input  wire                       rst_n,

    // Master 0
    input  wire                       m0_req_valid,
    output logic                      m0_req_ready,
    input  wire                       m0_req_write,
    input  wire clint_pkg::bus_addr_t m0_req_addr,
    input  wire clint_pkg::bus_data_t m0_req_wdata,
    input  wire clint_pkg::bus_strb_t m0_req_strb,
    output logic                      m0_rsp_valid,
    output clint_pkg::bus_data_t      m0_rsp_rdata,
    output logic                      m0_rsp_err,

    // Master 1
    input  wire                       m1_req_valid,
    output logic                      m1_req_ready,
    input  wire                       m1_req_write,
    input  wire clint_pkg::bus_addr_t m1_req_addr,
    input  wire clint_pkg::bus_data_t m1_req_wdata,
    input  wire clint_pkg::bus_strb_t m1_req_strb,
    output logic                      m1_rsp_valid,
    output clint_pkg::bus_data_t      m1_rsp_rdata,
    output logic                      m1_rsp_err,

    // Merged bus towards the register block
    output logic                      bus_valid,
    output logic                      bus_write,
    output clint_pkg::bus_addr_t      bus_addr,
    output clint_pkg::bus_data_t      bus_wdata,
    output clint_pkg::bus_strb_t      bus_strb,
    input  wire                       bus_rsp_valid,
    input  wire clint_pkg::bus_data_t bus_rsp_rdata,
    input  wire                       bus_rsp_err
);

    // Master that wins the next contended cycle
    clint_pkg::arb_owner_e prio;
    // Owner of the request in the bus stage, then of the response
    clint_pkg::arb_owner_e stage_owner;
    clint_pkg::arb_owner_e rsp_owner;

    logic contend;
    logic grant_m0;
    logic grant_m1;

    assign contend  = m0_req_valid && m1_req_valid;
    assign grant_m0 = m0_req_valid && (!m1_req_valid || prio == clint_pkg::OWNER_M0);
    assign grant_m1 = m1_req_valid && (!m0_req_valid || prio == clint_pkg::OWNER_M1);

    // No response back-pressure, so only the losing master is held off
    assign m0_req_ready = grant_m0;
    assign m1_req_ready = grant_m1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio      <= clint_pkg::OWNER_M0;
            bus_valid <= 1'b0;
        end else begin
            bus_valid <= grant_m0 || grant_m1;
            // Only a contended grant moves the priority
            if (contend) begin
                prio <= grant_m0 ? clint_pkg::OWNER_M1 : clint_pkg::OWNER_M0;
            end
        end
    end

    // Request payload and owner tags
    always_ff @(posedge clk) begin
        if (grant_m0) begin
            bus_write   <= m0_req_write;
            bus_addr    <= m0_req_addr;
            bus_wdata   <= m0_req_wdata;
            bus_strb    <= m0_req_strb;
            stage_owner <= clint_pkg::OWNER_M0;
        end else if (grant_m1) begin
            bus_write   <= m1_req_write;
            bus_addr    <= m1_req_addr;
            bus_wdata   <= m1_req_wdata;
            bus_strb    <= m1_req_strb;
            stage_owner <= clint_pkg::OWNER_M1;
        end
        // Tag follows the request into the response cycle
        if (bus_valid) begin
            rsp_owner <= stage_owner;
        end
    end

    // Steer the response to its owner
    assign m0_rsp_valid = bus_rsp_valid && (rsp_owner == clint_pkg::OWNER_M0);
    assign m1_rsp_valid = bus_rsp_valid && (rsp_owner == clint_pkg::OWNER_M1);
    assign m0_rsp_rdata = bus_rsp_rdata;
    assign m1_rsp_rdata = bus_rsp_rdata;
    assign m0_rsp_err   = bus_rsp_err && (rsp_owner == clint_pkg::OWNER_M0);
    assign m1_rsp_err   = bus_rsp_err && (rsp_owner == clint_pkg::OWNER_M1);

endmodule

`default_nettype wire

/* verilog/clint_tick_prescaler.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Clock prescaler producing the one-cycle mtime tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "clint_params.svh"

module clint_tick_prescaler (
    input  wire  clk,
    input  wire  rst_n,
    output logic mtime_tick
);

    localparam int TICK_DIV = `CLINT_TICK_DIV;
    // Counter needs at least one bit even for a divider of 1
    localparam int CNT_WIDTH = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(TICK_DIV - 1);

    logic [CNT_WIDTH-1:0] div_cnt;

    // Tick is registered on the wrap, so the first one lands
    // TICK_DIV cycles after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            mtime_tick <= 1'b0;
        end else if (div_cnt == CNT_LAST) begin
            div_cnt    <= '0;
            mtime_tick <= 1'b1;
        end else begin
            div_cnt    <= div_cnt + 1'b1;
            mtime_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/clint_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT register block: decode, msip, mtimecmp, mtime and interrupt lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "clint_params.svh"

module clint_regs (
    input  wire                       clk,
    input  wire                       rst_n,

    input  wire                       bus_valid,
    input  wire                       bus_write,
    input  wire clint_pkg::bus_addr_t bus_addr,
    input  wire clint_pkg::bus_data_t bus_wdata,
    input  wire clint_pkg::bus_strb_t bus_strb,
    output logic                      bus_rsp_valid,
    output clint_pkg::bus_data_t      bus_rsp_rdata,
    output logic                      bus_rsp_err,

    input  wire                       mtime_tick,
    output clint_pkg::hart_vec_t      hart_swi,
    output clint_pkg::hart_vec_t      hart_timeri
);

    localparam int AW = `CLINT_ADDR_WIDTH;
    localparam clint_pkg::bus_addr_t MSIP_BASE     = `CLINT_MSIP_BASE;
    localparam clint_pkg::bus_addr_t MTIMECMP_BASE = `CLINT_MTIMECMP_BASE;
    localparam clint_pkg::bus_addr_t MTIME_ADDR    = `CLINT_MTIME_ADDR;

    clint_pkg::mtime_t mtime;
    clint_pkg::mtime_t mtimecmp [`CLINT_HART_COUNT];

    // Decode results
    logic                msip_sel;
    logic                cmp_sel;
    logic                mtime_sel;
    logic                high_sel;
    logic                acc_err;
    clint_pkg::hart_id_t hart_sel;
    clint_pkg::bus_data_t rd_word;

    // Each region is one 4 KiB page; only aligned words decode
    always_comb begin
        msip_sel  = 1'b0;
        cmp_sel   = 1'b0;
        mtime_sel = 1'b0;
        hart_sel  = '0;
        high_sel  = bus_addr[2];
        if (bus_addr[1:0] == 2'b00) begin
            if (bus_addr[AW-1:12] == MSIP_BASE[AW-1:12]) begin
                // one word per hart
                hart_sel = clint_pkg::hart_id_t'(bus_addr[11:2]);
                msip_sel = (bus_addr[11:2] < 10'(`CLINT_HART_COUNT));
            end else if (bus_addr[AW-1:12] == MTIMECMP_BASE[AW-1:12]) begin
                // one doubleword per hart
                hart_sel = clint_pkg::hart_id_t'(bus_addr[11:3]);
                cmp_sel  = (bus_addr[11:3] < 9'(`CLINT_HART_COUNT));
            end else if (bus_addr[AW-1:3] == MTIME_ADDR[AW-1:3]) begin
                mtime_sel = 1'b1;
            end
        end
        // mtime is read-only from the bus
        acc_err = !(msip_sel || cmp_sel || mtime_sel) || (mtime_sel && bus_write);
    end

    // Read word for the decoded register
    always_comb begin
        rd_word = '0;
        if (msip_sel) begin
            rd_word[0] = hart_swi[hart_sel];
        end else if (cmp_sel) begin
            rd_word = high_sel ? mtimecmp[hart_sel][63:32] : mtimecmp[hart_sel][31:0];
        end else if (mtime_sel) begin
            rd_word = high_sel ? mtime[63:32] : mtime[31:0];
        end
    end

    // Timer state, software interrupt bits and response valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime         <= '0;
            hart_swi      <= '0;
            hart_timeri   <= '0;
            bus_rsp_valid <= 1'b0;
            for (int h = 0; h < `CLINT_HART_COUNT; h++) begin
                mtimecmp[h] <= '1;
            end
        end else begin
            mtime         <= mtime + 64'(mtime_tick);
            bus_rsp_valid <= bus_valid;

            // Compare against the current mtime, so the line trails by a cycle
            for (int h = 0; h < `CLINT_HART_COUNT; h++) begin
                hart_timeri[h] <= (mtime >= mtimecmp[h]);
            end

            if (bus_valid && bus_write && !acc_err) begin
                if (msip_sel && bus_strb[0]) begin
                    hart_swi[hart_sel] <= bus_wdata[0];
                end
                if (cmp_sel) begin
                    // byte merge into the selected half
                    for (int b = 0; b < `CLINT_DATA_WIDTH / 8; b++) begin
                        if (bus_strb[b]) begin
                            mtimecmp[hart_sel][(high_sel ? 32 : 0) + 8*b +: 8]
                                <= bus_wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Response payload, error accesses return zero
    always_ff @(posedge clk) begin
        if (bus_valid) begin
            bus_rsp_err   <= acc_err;
            bus_rsp_rdata <= acc_err ? '0 : rd_word;
        end
    end

endmodule

`default_nettype wire

/* verilog/clint_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT top: bus arbiter, tick prescaler and register block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clint_top (
    input  wire                       clk,
    input  wire                       rst_n,

    // Hart 0 side load/store port
    input  wire                       m0_req_valid,
    output logic                      m0_req_ready,
    input  wire                       m0_req_write,
    input  wire clint_pkg::bus_addr_t m0_req_addr,
    input  wire clint_pkg::bus_data_t m0_req_wdata,
    input  wire clint_pkg::bus_strb_t m0_req_strb,
    output logic                      m0_rsp_valid,
    output clint_pkg::bus_data_t      m0_rsp_rdata,
    output logic                      m0_rsp_err,

    // Hart 1 side load/store port
    input  wire                       m1_req_valid,
    output logic                      m1_req_ready,
    input  wire                       m1_req_write,
    input  wire clint_pkg::bus_addr_t m1_req_addr,
    input  wire clint_pkg::bus_data_t m1_req_wdata,
    input  wire clint_pkg::bus_strb_t m1_req_strb,
    output logic                      m1_rsp_valid,
    output clint_pkg::bus_data_t      m1_rsp_rdata,
    output logic                      m1_rsp_err,

    output clint_pkg::hart_vec_t      hart_swi,
    output clint_pkg::hart_vec_t      hart_timeri
);

    // Internal register bus
    logic                 bus_valid;
    logic                 bus_write;
    clint_pkg::bus_addr_t bus_addr;
    clint_pkg::bus_data_t bus_wdata;
    clint_pkg::bus_strb_t bus_strb;
    logic                 bus_rsp_valid;
    clint_pkg::bus_data_t bus_rsp_rdata;
    logic                 bus_rsp_err;
    logic                 mtime_tick;

    clint_bus_arbiter u_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .m0_req_valid  (m0_req_valid),
        .m0_req_ready  (m0_req_ready),
        .m0_req_write  (m0_req_write),
        .m0_req_addr   (m0_req_addr),
        .m0_req_wdata  (m0_req_wdata),
        .m0_req_strb   (m0_req_strb),
        .m0_rsp_valid  (m0_rsp_valid),
        .m0_rsp_rdata  (m0_rsp_rdata),
        .m0_rsp_err    (m0_rsp_err),
        .m1_req_valid  (m1_req_valid),
        .m1_req_ready  (m1_req_ready),
        .m1_req_write  (m1_req_write),
        .m1_req_addr   (m1_req_addr),
        .m1_req_wdata  (m1_req_wdata),
        .m1_req_strb   (m1_req_strb),
        .m1_rsp_valid  (m1_rsp_valid),
        .m1_rsp_rdata  (m1_rsp_rdata),
        .m1_rsp_err    (m1_rsp_err),
        .bus_valid     (bus_valid),
        .bus_write     (bus_write),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_strb      (bus_strb),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_rdata (bus_rsp_rdata),
        .bus_rsp_err   (bus_rsp_err)
    );

    clint_tick_prescaler u_prescaler (
        .clk        (clk),
        .rst_n      (rst_n),
        .mtime_tick (mtime_tick)
    );

    clint_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .bus_valid     (bus_valid),
        .bus_write     (bus_write),
        .bus_addr      (bus_addr),
        .bus_wdata     (bus_wdata),
        .bus_strb      (bus_strb),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp_rdata (bus_rsp_rdata),
        .bus_rsp_err   (bus_rsp_err),
        .mtime_tick    (mtime_tick),
        .hart_swi      (hart_swi),
        .hart_timeri   (hart_timeri)
    );

endmodule

`default_nettype wire

/* dv/clint_properties.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on the register block handshake and interrupt lines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module clint_properties (
    input wire                       clk,
    input wire                       rst_n,
    input wire                       bus_valid,
    input wire                       bus_rsp_valid,
    input wire clint_pkg::bus_data_t bus_rsp_rdata,
    input wire                       bus_rsp_err,
    input wire clint_pkg::hart_vec_t hart_timeri
);

    // One response per request, one cycle later
    a_rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp_valid == $past(bus_valid))
        else $error("bus_rsp_valid does not follow bus_valid by one cycle");

    a_err_zero_data: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_rsp_valid && bus_rsp_err) |-> (bus_rsp_rdata == '0))
        else $error("error response carries non-zero read data");

    // First cycle out of reset
    a_timer_low_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (hart_timeri == '0))
        else $error("hart_timeri is not low after reset");

endmodule

bind clint_regs clint_properties u_props (.*);

`default_nettype wire

/* dv/clint_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CLINT testbench: data-file driven masters, response and interrupt checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "clint_params.svh"

module clint_tb;

    localparam int K_READ = 0, K_WRITE = 1, K_SWI = 2, K_TIMERI = 3, K_READ_GE = 4;
    localparam int K_MARK = 5, K_DELTA = 6, K_IDLE = 7, K_PHASE = 8;
    localparam int MAX_LINES = 256;

    logic clk;
    logic rst_n;
    logic m0_req_valid, m0_req_ready, m0_req_write, m0_rsp_valid, m0_rsp_err;
    logic m1_req_valid, m1_req_ready, m1_req_write, m1_rsp_valid, m1_rsp_err;
    clint_pkg::bus_addr_t m0_req_addr, m1_req_addr;
    clint_pkg::bus_data_t m0_req_wdata, m1_req_wdata, m0_rsp_rdata, m1_rsp_rdata;
    clint_pkg::bus_strb_t m0_req_strb, m1_req_strb;
    clint_pkg::hart_vec_t hart_swi, hart_timeri;

    // Data file columns
    logic [3:0]           mst_col   [MAX_LINES];
    logic [3:0]           knd_col   [MAX_LINES];
    clint_pkg::bus_addr_t addr_col  [MAX_LINES];
    clint_pkg::bus_data_t wdata_col [MAX_LINES];
    clint_pkg::bus_strb_t strb_col  [MAX_LINES];
    clint_pkg::bus_data_t exp_col   [MAX_LINES];
    clint_pkg::bus_data_t mask_col  [MAX_LINES];
    logic                 err_col   [MAX_LINES];
    int                   line_col  [MAX_LINES];
    int                   nlines;

    // Outstanding requests per master: line index and due cycle
    int pend_idx0[$], pend_idx1[$], pend_due0[$], pend_due1[$];
    bit active [2];
    clint_pkg::bus_data_t mark_val [2];
    int mark_cyc [2];
    int cyc = 0;
    int limit;
    int fail_count;
    bit have_last;
    bit last_win;

    clint_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        fail_count++;
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] expv, input logic [31:0] actv);
        $display("error %s %s expected %h actual %h", name, what, expv, actv);
        stop_run();
    endtask

    task automatic issue_request(input int m, input int i);
        @(posedge clk);
        if (m == 0) begin
            m0_req_valid <= 1'b1;
            m0_req_write <= (knd_col[i] == K_WRITE);
            m0_req_addr  <= addr_col[i];
            m0_req_wdata <= wdata_col[i];
            m0_req_strb  <= strb_col[i];
        end else begin
            m1_req_valid <= 1'b1;
            m1_req_write <= (knd_col[i] == K_WRITE);
            m1_req_addr  <= addr_col[i];
            m1_req_wdata <= wdata_col[i];
            m1_req_strb  <= strb_col[i];
        end
        active[m] = 1'b1;
        forever begin
            @(negedge clk);
            if ((m == 0) ? m0_req_ready : m1_req_ready) break;
        end
        // Accepted at the next edge, response two edges after that
        if (m == 0) begin
            pend_idx0.push_back(i);
            pend_due0.push_back(cyc + 2);
        end else begin
            pend_idx1.push_back(i);
            pend_due1.push_back(cyc + 2);
        end
    endtask

    task automatic release_request(input int m);
        if (active[m]) begin
            @(posedge clk);
            if (m == 0) m0_req_valid <= 1'b0;
            else m1_req_valid <= 1'b0;
            active[m] = 1'b0;
        end
    endtask

    // Queues change on the falling edge, so they are polled on the rising one
    task automatic wait_drained(input int m);
        @(posedge clk);
        while (((m == 0) ? pend_idx0.size() : pend_idx1.size()) != 0) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_master(input int m, input int s, input int e, input bit nogap);
        int g;
        int n;
        string name;
        for (int i = s; i < e; i++) begin
            if (int'(mst_col[i]) != m) continue;
            name = $sformatf("line %0d", line_col[i]);
            case (int'(knd_col[i]))
                K_SWI: begin
                    release_request(m);
                    wait_drained(m);
                    assert ((hart_swi & mask_col[i][3:0]) == (exp_col[i][3:0] & mask_col[i][3:0]))
                    else report_mismatch(name, "hart_swi", exp_col[i], 32'(hart_swi));
                end
                K_TIMERI: begin
                    release_request(m);
                    wait_drained(m);
                    n = 0;
                    while ((hart_timeri & mask_col[i][3:0]) != exp_col[i][3:0]
                           && n < int'(wdata_col[i])) begin
                        @(negedge clk);
                        n++;
                    end
                    assert ((hart_timeri & mask_col[i][3:0]) == exp_col[i][3:0])
                    else report_mismatch(name, "hart_timeri", exp_col[i], 32'(hart_timeri));
                end
                K_IDLE: begin
                    release_request(m);
                    repeat (int'(wdata_col[i])) @(posedge clk);
                end
                default: begin
                    if (!nogap) begin
                        g = $urandom_range(2, 0);
                        if (g > 0) begin
                            release_request(m);
                            repeat (g) @(posedge clk);
                        end
                    end
                    issue_request(m, i);
                end
            endcase
        end
        release_request(m);
    endtask

    task automatic check_response(input int m, input int i,
                                  input clint_pkg::bus_data_t rdata, input logic err);
        string name;
        clint_pkg::bus_data_t diff;
        int ticks;
        name = $sformatf("line %0d", line_col[i]);
        assert (err == err_col[i])
        else report_mismatch(name, "rsp_err", 32'(err_col[i]), 32'(err));
        case (int'(knd_col[i]))
            K_READ_GE: begin
                assert (rdata >= exp_col[i])
                else report_mismatch(name, "rdata lower bound", exp_col[i], rdata);
            end
            K_MARK: begin
                mark_val[m] = rdata;
                mark_cyc[m] = cyc;
            end
            K_DELTA: begin
                ticks = (cyc - mark_cyc[m]) / `CLINT_TICK_DIV;
                diff  = rdata - mark_val[m];
                assert (int'(diff) >= ticks - 1 && int'(diff) <= ticks + 1)
                else report_mismatch(name, "mtime delta", 32'(ticks), diff);
            end
            default: begin
                assert ((rdata & mask_col[i]) == (exp_col[i] & mask_col[i]))
                else report_mismatch(name, "rdata", exp_col[i] & mask_col[i],
                                     rdata & mask_col[i]);
            end
        endcase
    endtask

    task automatic check_port(input int m, input logic valid,
                              input clint_pkg::bus_data_t rdata, input logic err);
        bit has;
        int idx;
        int due;
        has = ((m == 0) ? pend_idx0.size() : pend_idx1.size()) != 0;
        idx = 0;
        due = 0;
        if (has) begin
            idx = (m == 0) ? pend_idx0[0] : pend_idx1[0];
            due = (m == 0) ? pend_due0[0] : pend_due1[0];
        end
        if (valid) begin
            if (!has) report_failure($sformatf("master %0d got a response it never asked for", m));
            assert (cyc == due)
            else report_failure($sformatf("master %0d response came at the wrong cycle", m));
            if (m == 0) begin
                void'(pend_idx0.pop_front());
                void'(pend_due0.pop_front());
            end else begin
                void'(pend_idx1.pop_front());
                void'(pend_due1.pop_front());
            end
            check_response(m, idx, rdata, err);
        end else if (has && cyc >= due) begin
            report_failure($sformatf("master %0d response did not arrive", m));
        end
    endtask

    // Responses and arbitration are sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_port(0, m0_rsp_valid, m0_rsp_rdata, m0_rsp_err);
            check_port(1, m1_rsp_valid, m1_rsp_rdata, m1_rsp_err);
            if (m0_req_valid && m1_req_valid) begin
                assert (m0_req_ready != m1_req_ready)
                else report_failure("contended cycle did not grant exactly one master");
                if (have_last) begin
                    assert (m1_req_ready != last_win)
                    else report_failure("contended grants did not alternate");
                end
                last_win  = m1_req_ready;
                have_last = 1'b1;
            end else begin
                assert ((!m0_req_valid || m0_req_ready) && (!m1_req_valid || m1_req_ready))
                else report_failure("lone requester was not granted");
            end
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= limit) report_failure("timeout, the run took too many cycles");
    end

    initial begin
        int fd;
        int ln;
        int s;
        int e;
        bit nogap;
        string line;
        logic [3:0] f_m, f_k;
        clint_pkg::bus_addr_t f_a;
        clint_pkg::bus_data_t f_w, f_x, f_k2;
        clint_pkg::bus_strb_t f_s;
        logic f_e;
        void'($urandom(32'h5b3a));
        rst_n <= 1'b0;
        {m0_req_valid, m0_req_write, m1_req_valid, m1_req_write} <= '0;
        {m0_req_addr, m0_req_wdata, m0_req_strb} <= '0;
        {m1_req_addr, m1_req_wdata, m1_req_strb} <= '0;
        limit = 100000;
        fail_count = 0;
        nlines = 0;
        ln = 0;
        fd = $fopen("dv/clint_testdata.txt", "r");
        if (fd == 0) report_failure("could not open dv/clint_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            ln++;
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if ($sscanf(line, "%h %h %h %h %h %h %h %h",
                        f_m, f_k, f_a, f_w, f_s, f_x, f_k2, f_e) == 8) begin
                mst_col[nlines]   = f_m;
                knd_col[nlines]   = f_k;
                addr_col[nlines]  = f_a;
                wdata_col[nlines] = f_w;
                strb_col[nlines]  = f_s;
                exp_col[nlines]   = f_x;
                mask_col[nlines]  = f_k2;
                err_col[nlines]   = f_e;
                line_col[nlines]  = ln;
                nlines++;
            end
        end
        $fclose(fd);
        limit = 40 * nlines + 2000;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        // Each phase runs both masters side by side
        s = 0;
        while (s < nlines) begin
            nogap = 1'b0;
            if (int'(knd_col[s]) == K_PHASE) begin
                nogap = wdata_col[s][0];
                s++;
            end
            e = s;
            while (e < nlines && int'(knd_col[e]) != K_PHASE) e++;
            fork
                run_master(0, s, e, nogap);
                run_master(1, s, e, nogap);
            join
            wait_drained(0);
            wait_drained(1);
            s = e;
        end

        repeat (4) @(posedge clk);
        if (fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
verilog/clint_pkg.sv
verilog/clint_bus_arbiter.sv
verilog/clint_tick_prescaler.sv
verilog/clint_regs.sv
verilog/clint_top.sv
dv/clint_properties.sv
dv/clint_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CLINT testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f sources.f --top-module clint_tb -o clint_sim

# The simulator exits non-zero on a failure; the log decides the verdict
./obj_dir/clint_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* dv/clint_testdata.txt */
# master kind addr wdata strb exp_rdata rd_mask exp_err, all hex; kinds: 0 read 1 write
# 2 swi check 3 timeri wait (wdata=cycles) 4 read>=exp 5 mtime mark 6 mtime delta 7 idle 8 phase
0 8 0000 00000000 0 00000000 00000000 0
0 1 0000 00000001 1 00000000 00000000 0
0 2 0000 00000000 0 00000001 0000000f 0
0 0 0000 00000000 0 00000001 ffffffff 0
0 1 0000 00000000 1 00000000 00000000 0
0 2 0000 00000000 0 00000000 0000000f 0
0 1 0004 00000001 1 00000000 00000000 0
0 2 0000 00000000 0 00000002 0000000f 0
0 1 0004 00000000 1 00000000 00000000 0
0 1 0008 00000001 1 00000000 00000000 0
0 2 0000 00000000 0 00000004 0000000f 0
0 1 0008 00000000 1 00000000 00000000 0
0 1 000c 00000001 1 00000000 00000000 0
0 0 000c 00000000 0 00000001 ffffffff 0
0 2 0000 00000000 0 00000008 0000000f 0
0 1 000c 00000000 1 00000000 00000000 0
0 0 000c 00000000 0 00000000 ffffffff 0
0 2 0000 00000000 0 00000000 0000000f 0
1 8 0000 00000000 0 00000000 00000000 0
1 0 4008 00000000 0 ffffffff ffffffff 0
1 0 400c 00000000 0 ffffffff ffffffff 0
1 1 4008 aabbccdd 5 00000000 00000000 0
1 0 4008 00000000 0 ffbbffdd ffffffff 0
1 1 400c 00000012 1 00000000 00000000 0
1 0 400c 00000000 0 ffffff12 ffffffff 0
0 8 0000 00000000 0 00000000 00000000 0
0 0 2000 00000000 0 00000000 ffffffff 1
0 1 2000 deadbeef f 00000000 ffffffff 1
0 1 0010 00000001 1 00000000 ffffffff 1
0 1 4020 00000000 f 00000000 ffffffff 1
0 1 bff8 00000000 f 00000000 ffffffff 1
0 0 0002 00000000 0 00000000 ffffffff 1
0 2 0000 00000000 0 00000000 0000000f 0
0 0 4000 00000000 0 ffffffff ffffffff 0
0 0 bffc 00000000 0 00000000 ffffffff 0
0 8 0000 00000000 0 00000000 00000000 0
0 3 0000 00000000 0 00000000 0000000f 0
0 1 4010 00000040 f 00000000 00000000 0
0 1 4014 00000000 f 00000000 00000000 0
0 3 0000 00000200 0 00000004 0000000f 0
0 4 bff8 00000000 0 00000040 ffffffff 0
0 0 bffc 00000000 0 00000000 ffffffff 0
0 1 4014 ffffffff f 00000000 00000000 0
0 3 0000 00000002 0 00000000 0000000f 0
0 8 0000 00000001 0 00000000 00000000 0
0 1 0004 00000001 1 00000000 00000000 0
1 1 0008 00000001 1 00000000 00000000 0
0 0 0004 00000000 0 00000001 ffffffff 0
1 0 0008 00000000 0 00000001 ffffffff 0
0 0 400c 00000000 0 ffffff12 ffffffff 0
1 0 4000 00000000 0 ffffffff ffffffff 0
0 0 4008 00000000 0 ffbbffdd ffffffff 0
1 0 4018 00000000 0 ffffffff ffffffff 0
0 0 0004 00000000 0 00000001 ffffffff 0
1 0 0000 00000000 0 00000000 ffffffff 0
0 8 0000 00000000 0 00000000 00000000 0
0 2 0000 00000000 0 00000006 0000000f 0
0 1 0004 00000000 1 00000000 00000000 0
0 1 0008 00000000 1 00000000 00000000 0
0 2 0000 00000000 0 00000000 0000000f 0
1 8 0000 00000000 0 00000000 00000000 0
1 5 bff8 00000000 0 00000000 00000000 0
1 7 0000 00000040 0 00000000 00000000 0
1 6 bff8 00000000 0 00000000 00000000 0
